//--- common/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// instruction memory depth in words
`define CORE_IMEM_WORDS 256

// data memory depth in words
`define CORE_DMEM_WORDS 256

// first fetch address after start
`define CORE_RESET_PC 32'h0000_0000

`endif

//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

  typedef logic [31:0] word_t;

  // rv32i major opcodes in the subset
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_IMM    = 7'b0010011,
    OP_STORE  = 7'b0100011,
    OP_REG    = 7'b0110011,
    OP_BRANCH = 7'b1100011
  } opcode_t;

  typedef enum logic [2:0] {
    ADD = 3'd0,  // zero so a cleared control is harmless
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SLT = 3'd5
  } alu_op_t;

  typedef enum logic [1:0] {
    MEM_NO_OP = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_t;

  typedef enum logic [1:0] {
    BR_NONE = 2'd0,
    BR_EQ   = 2'd1,
    BR_NE   = 2'd2
  } branch_op_t;

  typedef struct packed {
    alu_op_t    alu_op;
    logic       use_imm;
    mem_op_t    mem_op;
    branch_op_t branch_op;
    logic       reg_write;
    logic [4:0] write_back_id;
  } control_t;

  typedef struct packed {
    logic [4:0] id;
    word_t      data;
  } retire_t;

  typedef struct packed {
    word_t addr;  // word address, not byte
    word_t data;
  } store_t;

endpackage

`default_nettype wire

//--- design/instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module instr_fetch import core_pkg::*; (
  input  logic  sys_clk,
  input  logic  reset,
  input  logic  start,
  input  logic  stall,
  input  logic  load_valid,
  input  word_t load_addr,
  input  word_t load_data,
  input  logic  branch_taken,
  input  word_t branch_target,
  output word_t pc,
  output word_t instruction
);

  localparam int IMEM_AW = $clog2(`CORE_IMEM_WORDS);

  word_t imem [`CORE_IMEM_WORDS];

  // program load port, word indexed
  always_ff @(posedge sys_clk) begin
    if (load_valid) begin
      imem[load_addr[IMEM_AW-1:0]] <= load_data;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset || !start) begin
      pc <= `CORE_RESET_PC;
    end else if (branch_taken) begin
      pc <= branch_target;  // redirect beats a stall
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  assign instruction = imem[pc[IMEM_AW+1:2]];

endmodule

`default_nettype wire

//--- design/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode import core_pkg::*; (
  input  logic       sys_clk,
  input  logic       reset,
  input  word_t      instruction,
  input  logic       wb_write,
  input  logic [4:0] wb_id,
  input  word_t      wb_data,
  output control_t   control,
  output word_t      read1_data,
  output word_t      read2_data,
  output word_t      immediate,
  output logic [4:0] rs1,
  output logic [4:0] rs2
);

  word_t      regs [32];
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rd;
  logic       uses_rs1;
  logic       uses_rs2;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;

  assign opcode = instruction[6:0];
  assign rd     = instruction[11:7];
  assign funct3 = instruction[14:12];
  assign funct7 = instruction[31:25];

  assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
  assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
  assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                  instruction[30:25], instruction[11:8], 1'b0};

  always_comb begin
    control               = '0;  // unknown opcode stays a nop
    control.write_back_id = rd;
    immediate             = '0;
    uses_rs1              = 1'b0;
    uses_rs2              = 1'b0;
    case (opcode)
      OP_REG: begin
        uses_rs1          = 1'b1;
        uses_rs2          = 1'b1;
        control.reg_write = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: control.alu_op = ADD;
          {7'b0100000, 3'b000}: control.alu_op = SUB;
          {7'b0000000, 3'b111}: control.alu_op = AND;
          {7'b0000000, 3'b110}: control.alu_op = OR;
          {7'b0000000, 3'b100}: control.alu_op = XOR;
          {7'b0000000, 3'b010}: control.alu_op = SLT;
          default: begin
            control.reg_write = 1'b0;
            uses_rs1          = 1'b0;
            uses_rs2          = 1'b0;
          end
        endcase
      end
      OP_IMM: begin
        if (funct3 == 3'b000) begin  // addi only
          uses_rs1          = 1'b1;
          control.use_imm   = 1'b1;
          control.reg_write = 1'b1;
          immediate         = imm_i;
        end
      end
      OP_LOAD: begin
        if (funct3 == 3'b010) begin
          uses_rs1          = 1'b1;
          control.use_imm   = 1'b1;
          control.mem_op    = MEM_LOAD;
          control.reg_write = 1'b1;
          immediate         = imm_i;
        end
      end
      OP_STORE: begin
        if (funct3 == 3'b010) begin
          uses_rs1        = 1'b1;
          uses_rs2        = 1'b1;
          control.use_imm = 1'b1;
          control.mem_op  = MEM_STORE;
          immediate       = imm_s;
        end
      end
      OP_BRANCH: begin
        if (funct3 == 3'b000 || funct3 == 3'b001) begin
          uses_rs1          = 1'b1;
          uses_rs2          = 1'b1;
          control.branch_op = (funct3 == 3'b000) ? BR_EQ : BR_NE;
          immediate         = imm_b;
        end
      end
      default: ;
    endcase
  end

  // unused sources read as x0 so they never match a hazard
  assign rs1 = uses_rs1 ? instruction[19:15] : 5'd0;
  assign rs2 = uses_rs2 ? instruction[24:20] : 5'd0;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_write && wb_id != 5'd0) begin
      regs[wb_id] <= wb_data;
    end
  end

  // write-first bypass
  assign read1_data = (rs1 == 5'd0) ? '0 :
                      (wb_write && wb_id == rs1) ? wb_data : regs[rs1];
  assign read2_data = (rs2 == 5'd0) ? '0 :
                      (wb_write && wb_id == rs2) ? wb_data : regs[rs2];

endmodule

`default_nettype wire

//--- design/hazard_forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_forward_unit import core_pkg::*; (
  input  logic [4:0] rs1_id,
  input  logic [4:0] rs2_id,
  input  logic [4:0] rs1_ex,
  input  logic [4:0] rs2_ex,
  input  control_t   control_ex,
  input  control_t   control_mem,
  input  control_t   control_wb,
  input  word_t      alu_res_mem,
  input  word_t      wb_data,
  output logic       stall,
  output logic       fw1_valid,
  output word_t      fw1_data,
  output logic       fw2_valid,
  output word_t      fw2_data
);

  logic load_in_ex;

  // newest writer wins, memory stage before writeback
  function automatic logic [32:0] pick_source(input logic [4:0] rs);
    if (rs != 5'd0 && control_mem.reg_write && control_mem.write_back_id == rs) begin
      return {1'b1, alu_res_mem};
    end else if (rs != 5'd0 && control_wb.reg_write && control_wb.write_back_id == rs) begin
      return {1'b1, wb_data};
    end
    return {1'b0, 32'd0};
  endfunction

  assign load_in_ex = (control_ex.mem_op == MEM_LOAD) && (control_ex.write_back_id != 5'd0);

  // load result not ready until writeback
  assign stall = load_in_ex &&
                 (control_ex.write_back_id == rs1_id || control_ex.write_back_id == rs2_id);

  always_comb begin
    {fw1_valid, fw1_data} = pick_source(rs1_ex);
    {fw2_valid, fw2_data} = pick_source(rs2_ex);
  end

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import core_pkg::*; (
  input  word_t    pc,
  input  word_t    data1,
  input  word_t    data2,
  input  word_t    immediate,
  input  control_t control,
  input  logic     fw1_valid,
  input  word_t    fw1_data,
  input  logic     fw2_valid,
  input  word_t    fw2_data,
  output word_t    alu_res,
  output word_t    store_data,
  output logic     branch_taken,
  output word_t    branch_target
);

  word_t op1;
  word_t op2;
  word_t alu_b;

  assign op1   = fw1_valid ? fw1_data : data1;
  assign op2   = fw2_valid ? fw2_data : data2;
  assign alu_b = control.use_imm ? immediate : op2;

  assign store_data = op2;  // sw data is the forwarded rs2

  always_comb begin
    case (control.alu_op)
      ADD:     alu_res = op1 + alu_b;
      SUB:     alu_res = op1 - alu_b;
      AND:     alu_res = op1 & alu_b;
      OR:      alu_res = op1 | alu_b;
      XOR:     alu_res = op1 ^ alu_b;
      SLT:     alu_res = {31'd0, $signed(op1) < $signed(alu_b)};
      default: alu_res = '0;
    endcase
  end

  always_comb begin
    case (control.branch_op)
      BR_EQ:   branch_taken = (op1 == op2);
      BR_NE:   branch_taken = (op1 != op2);
      default: branch_taken = 1'b0;
    endcase
  end

  assign branch_target = pc + immediate;

endmodule

`default_nettype wire

//--- design/data_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module data_memory import core_pkg::*; (
  input  logic     sys_clk,
  input  logic     reset,
  input  control_t control,
  input  word_t    addr,
  input  word_t    write_data,
  output word_t    read_data,
  output logic     store_valid,
  output store_t   store
);

  localparam int DMEM_AW = $clog2(`CORE_DMEM_WORDS);

  word_t              dmem [`CORE_DMEM_WORDS];
  logic [DMEM_AW-1:0] index;

  assign index     = addr[DMEM_AW+1:2];  // byte address, word aligned
  assign read_data = dmem[index];

  assign store_valid = (control.mem_op == MEM_STORE);
  assign store.addr  = {2'b00, addr[31:2]};
  assign store.data  = write_data;

  always_ff @(posedge sys_clk) begin
    if (reset) begin
      for (int i = 0; i < `CORE_DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (store_valid) begin
      dmem[index] <= write_data;
    end
  end

endmodule

`default_nettype wire

//--- design/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top import core_pkg::*; (
  input  logic    sys_clk,
  input  logic    reset,
  input  logic    load_valid,
  input  word_t   load_addr,
  input  word_t   load_data,
  input  logic    start,
  output logic    retire_valid,
  output retire_t retire,
  output logic    store_valid,
  output store_t  store
);

  word_t      pc_if;
  word_t      instr_if;

  word_t      pc_id;
  word_t      instr_id;
  control_t   control_id;
  word_t      read1_data_id;
  word_t      read2_data_id;
  word_t      immediate_id;
  logic [4:0] rs1_id;
  logic [4:0] rs2_id;
  logic       stall;

  word_t      pc_ex;
  word_t      data1_ex;
  word_t      data2_ex;
  word_t      immediate_ex;
  logic [4:0] rs1_ex;
  logic [4:0] rs2_ex;
  control_t   control_ex;
  word_t      alu_res_ex;
  word_t      store_data_ex;
  logic       branch_taken_ex;
  word_t      branch_target_ex;
  logic       fw1_valid;
  word_t      fw1_data;
  logic       fw2_valid;
  word_t      fw2_data;

  control_t   control_mem;
  word_t      alu_res_mem;
  word_t      store_data_mem;
  logic       branch_taken_mem;
  word_t      branch_target_mem;
  word_t      load_data_mem;

  control_t   control_wb;
  word_t      alu_res_wb;
  word_t      load_data_wb;
  word_t      wb_data_wb;

  always_ff @(posedge sys_clk) begin
    if (reset || !start) begin
      pc_id             <= '0;
      instr_id          <= '0;
      pc_ex             <= '0;
      data1_ex          <= '0;
      data2_ex          <= '0;
      immediate_ex      <= '0;
      rs1_ex            <= '0;
      rs2_ex            <= '0;
      control_ex        <= '0;
      control_mem       <= '0;
      alu_res_mem       <= '0;
      store_data_mem    <= '0;
      branch_taken_mem  <= 1'b0;
      branch_target_mem <= '0;
      control_wb        <= '0;
      alu_res_wb        <= '0;
      load_data_wb      <= '0;
    end else begin
      // IF/ID
      if (branch_taken_mem) begin
        pc_id    <= '0;
        instr_id <= '0;  // all zero decodes as nop
      end else if (!stall) begin
        pc_id    <= pc_if;
        instr_id <= instr_if;
      end

      // ID/EX
      pc_ex        <= pc_id;
      data1_ex     <= read1_data_id;
      data2_ex     <= read2_data_id;
      immediate_ex <= immediate_id;
      rs1_ex       <= rs1_id;
      rs2_ex       <= rs2_id;
      control_ex   <= control_id;
      if (branch_taken_mem) begin
        control_ex <= '0;
      end else if (stall) begin
        control_ex.reg_write <= 1'b0;  // bubble
        control_ex.mem_op    <= MEM_NO_OP;
        control_ex.branch_op <= BR_NONE;
      end

      // EX/MEM, squashed slot must not branch again
      alu_res_mem       <= alu_res_ex;
      store_data_mem    <= store_data_ex;
      branch_taken_mem  <= branch_taken_ex && !branch_taken_mem;
      branch_target_mem <= branch_target_ex;
      control_mem       <= branch_taken_mem ? '0 : control_ex;

      // MEM/WB
      control_wb   <= control_mem;
      alu_res_wb   <= alu_res_mem;
      load_data_wb <= load_data_mem;
    end
  end

  assign wb_data_wb = (control_wb.mem_op == MEM_LOAD) ? load_data_wb : alu_res_wb;

  assign retire_valid = control_wb.reg_write && (control_wb.write_back_id != 5'd0);
  assign retire.id    = control_wb.write_back_id;
  assign retire.data  = wb_data_wb;

  instr_fetch u_instr_fetch (
    .sys_clk       (sys_clk),
    .reset         (reset),
    .start         (start),
    .stall         (stall),
    .load_valid    (load_valid),
    .load_addr     (load_addr),
    .load_data     (load_data),
    .branch_taken  (branch_taken_mem),
    .branch_target (branch_target_mem),
    .pc            (pc_if),
    .instruction   (instr_if)
  );

  instr_decode u_instr_decode (
    .sys_clk     (sys_clk),
    .reset       (reset),
    .instruction (instr_id),
    .wb_write    (control_wb.reg_write),
    .wb_id       (control_wb.write_back_id),
    .wb_data     (wb_data_wb),
    .control     (control_id),
    .read1_data  (read1_data_id),
    .read2_data  (read2_data_id),
    .immediate   (immediate_id),
    .rs1         (rs1_id),
    .rs2         (rs2_id)
  );

  hazard_forward_unit u_hazard_forward_unit (
    .rs1_id      (rs1_id),
    .rs2_id      (rs2_id),
    .rs1_ex      (rs1_ex),
    .rs2_ex      (rs2_ex),
    .control_ex  (control_ex),
    .control_mem (control_mem),
    .control_wb  (control_wb),
    .alu_res_mem (alu_res_mem),
    .wb_data     (wb_data_wb),
    .stall       (stall),
    .fw1_valid   (fw1_valid),
    .fw1_data    (fw1_data),
    .fw2_valid   (fw2_valid),
    .fw2_data    (fw2_data)
  );

  execute_stage u_execute_stage (
    .pc            (pc_ex),
    .data1         (data1_ex),
    .data2         (data2_ex),
    .immediate     (immediate_ex),
    .control       (control_ex),
    .fw1_valid     (fw1_valid),
    .fw1_data      (fw1_data),
    .fw2_valid     (fw2_valid),
    .fw2_data      (fw2_data),
    .alu_res       (alu_res_ex),
    .store_data    (store_data_ex),
    .branch_taken  (branch_taken_ex),
    .branch_target (branch_target_ex)
  );

  data_memory u_data_memory (
    .sys_clk     (sys_clk),
    .reset       (reset),
    .control     (control_mem),
    .addr        (alu_res_mem),
    .write_data  (store_data_mem),
    .read_data   (load_data_mem),
    .store_valid (store_valid),
    .store       (store)
  );

endmodule

`default_nettype wire

//--- bench/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

`include "core_settings.svh"

localparam int MODEL_DMEM_AW = $clog2(`CORE_DMEM_WORDS);

// runs the program one instruction at a time, fills exp_retires and exp_stores
// returns 0 if the self-branch is never reached
function automatic bit run_model(input word_t code [PROG_WORDS]);
  word_t   regs [32];
  word_t   mem [`CORE_DMEM_WORDS];
  word_t   pc;
  word_t   next_pc;
  word_t   ins;
  word_t   a;
  word_t   b;
  word_t   res;
  word_t   addr;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_b;
  logic    write;
  retire_t ret;
  store_t  st;
  for (int i = 0; i < 32; i++) begin
    regs[i] = '0;
  end
  for (int i = 0; i < `CORE_DMEM_WORDS; i++) begin
    mem[i] = '0;
  end
  pc = `CORE_RESET_PC;
  for (int step = 0; step < 4096; step++) begin
    ins = code[pc[7:2]];  // 64-word program window
    if (ins == 32'h0000_0063) begin
      return 1'b1;  // beq x0,x0,0
    end
    a       = regs[ins[19:15]];
    b       = regs[ins[24:20]];
    imm_i   = {{20{ins[31]}}, ins[31:20]};
    imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    write   = 1'b0;
    res     = '0;
    next_pc = pc + 32'd4;
    case (ins[6:0])
      7'b0110011: begin
        write = 1'b1;
        case ({ins[30], ins[14:12]})
          4'b0000: res = a + b;
          4'b1000: res = a - b;
          4'b0111: res = a & b;
          4'b0110: res = a | b;
          4'b0100: res = a ^ b;
          default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
      end
      7'b0010011: begin
        write = 1'b1;
        res   = a + imm_i;
      end
      7'b0000011: begin
        write = 1'b1;
        addr  = a + imm_i;
        res   = mem[addr[MODEL_DMEM_AW+1:2]];
      end
      7'b0100011: begin
        addr = a + imm_s;
        mem[addr[MODEL_DMEM_AW+1:2]] = b;
        st.addr = addr >> 2;  // word address
        st.data = b;
        exp_stores.push_back(st);
      end
      7'b1100011: begin
        if (ins[12] ? (a != b) : (a == b)) begin
          next_pc = pc + imm_b;
        end
      end
      default: ;
    endcase
    if (write && ins[11:7] != 5'd0) begin
      regs[ins[11:7]] = res;
      ret.id   = ins[11:7];
      ret.data = res;
      exp_retires.push_back(ret);
    end
    pc = next_pc;
  end
  return 1'b0;
endfunction

`endif

//--- bench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import core_pkg::*; ();

  localparam int PROG_WORDS = 64;
  localparam int RAND_LEN   = 40;
  localparam int TIMEOUT    = 2000;

  logic    sys_clk;
  logic    reset;
  logic    load_valid;
  word_t   load_addr;
  word_t   load_data;
  logic    start;
  logic    retire_valid;
  retire_t retire;
  logic    store_valid;
  store_t  store;

  word_t   prog [PROG_WORDS];
  int      prog_len;
  int      seed = 32'h885b;
  retire_t exp_retires [$];
  store_t  exp_stores [$];

  `include "isa_model.svh"

  cpu_top u_cpu_top (
    .sys_clk      (sys_clk),
    .reset        (reset),
    .load_valid   (load_valid),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .start        (start),
    .retire_valid (retire_valid),
    .retire       (retire),
    .store_valid  (store_valid),
    .store        (store)
  );

  initial begin
    sys_clk = 1'b0;
    forever #5 sys_clk = ~sys_clk;
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "stopped on first error");
  endtask

  task automatic check_retire(input retire_t got, input retire_t exp);
    if (got !== exp) begin
      $display("FAIL %0t: retire x%0d=%h, expected x%0d=%h",
               $time, got.id, got.data, exp.id, exp.data);
      abort_run();
    end
  endtask

  task automatic check_store(input store_t got, input store_t exp);
    if (got !== exp) begin
      $display("FAIL %0t: store [%0h]=%h, expected [%0h]=%h",
               $time, got.addr, got.data, exp.addr, exp.data);
      abort_run();
    end
  endtask

  // outputs come from registers, so the falling edge sees them settled
  always @(negedge sys_clk) begin
    if (retire_valid) begin
      if (exp_retires.size() == 0) begin
        $display("retire of x%0d at %0t was not expected", retire.id, $time);
        abort_run();
      end else begin
        check_retire(retire, exp_retires.pop_front());
      end
    end
  end

  always @(negedge sys_clk) begin
    if (store_valid) begin
      if (exp_stores.size() == 0) begin
        $display("store to word %0h at %0t was not expected", store.addr, $time);
        abort_run();
      end else begin
        check_store(store, exp_stores.pop_front());
      end
    end
  end

  function automatic word_t rtype_word(input alu_op_t op, input int rd, input int rs1,
                                       input int rs2);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = (op == SUB) ? 7'b0100000 : 7'b0000000;
    case (op)
      AND:     f3 = 3'b111;
      OR:      f3 = 3'b110;
      XOR:     f3 = 3'b100;
      SLT:     f3 = 3'b010;
      default: f3 = 3'b000;
    endcase
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
  endfunction

  function automatic word_t itype_word(input logic [6:0] opcode, input logic [2:0] f3,
                                       input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opcode};
  endfunction

  function automatic word_t addi_word(input int rd, input int rs1, input int imm);
    return itype_word(7'b0010011, 3'b000, rd, rs1, imm);
  endfunction

  function automatic word_t lw_word(input int rd, input int rs1, input int imm);
    return itype_word(7'b0000011, 3'b010, rd, rs1, imm);
  endfunction

  function automatic word_t sw_word(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // is_ne picks bne over beq, off in bytes
  function automatic word_t branch_word(input bit is_ne, input int rs1, input int rs2,
                                        input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], 2'b00, is_ne, off[4:1], off[11],
            7'b1100011};
  endfunction

  function automatic int pick_reg();
    return 1 + $unsigned($random(seed)) % 7;  // x1..x7
  endfunction

  task automatic clear_program();
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i] = '0;
    end
    prog_len = 0;
  endtask

  task automatic emit(input word_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  task automatic run_program(input string name);
    int cycles;
    exp_retires.delete();
    exp_stores.delete();
    if (!run_model(prog)) begin
      $display("model of %s never reached the self-branch", name);
      abort_run();
    end
    @(negedge sys_clk);
    reset = 1'b1;
    start = 1'b0;
    repeat (4) @(negedge sys_clk);
    reset = 1'b0;
    for (int i = 0; i < PROG_WORDS; i++) begin
      load_valid = 1'b1;
      load_addr  = i;
      load_data  = prog[i];
      @(negedge sys_clk);
    end
    load_valid = 1'b0;
    start      = 1'b1;
    cycles     = 0;
    while ((exp_retires.size() != 0 || exp_stores.size() != 0) && cycles < TIMEOUT) begin
      @(negedge sys_clk);
      cycles++;
    end
    if (exp_retires.size() != 0 || exp_stores.size() != 0) begin
      $display("timeout in %s with %0d retires and %0d stores still missing",
               name, exp_retires.size(), exp_stores.size());
      abort_run();
    end
    repeat (8) @(negedge sys_clk);  // catch late extra pulses
    start = 1'b0;
    $display("%s program done", name);
  endtask

  task automatic alu_program();
    clear_program();
    emit(addi_word(1, 0, 100));
    emit(addi_word(2, 0, -7));
    emit(addi_word(3, 0, 2047));
    emit(addi_word(4, 0, -2048));
    emit(rtype_word(ADD, 5, 1, 2));
    emit(rtype_word(SUB, 6, 2, 1));
    emit(rtype_word(AND, 7, 1, 3));
    emit(rtype_word(OR, 8, 2, 1));
    emit(rtype_word(XOR, 9, 3, 4));
    emit(rtype_word(SLT, 10, 2, 1));  // negative less than positive
    emit(rtype_word(SLT, 11, 1, 2));
    emit(rtype_word(SLT, 12, 4, 2));
    emit(addi_word(13, 5, -100));
    emit(branch_word(1'b0, 0, 0, 0));
    run_program("alu");
  endtask

  task automatic forwarding_program();
    clear_program();
    emit(addi_word(1, 0, 5));
    emit(addi_word(2, 1, 3));
    emit(rtype_word(ADD, 3, 2, 1));  // x1 from two back
    emit(rtype_word(SUB, 4, 3, 2));
    emit(rtype_word(XOR, 5, 4, 3));
    emit(rtype_word(OR, 6, 5, 1));
    emit(rtype_word(SLT, 7, 4, 6));
    emit(rtype_word(ADD, 7, 7, 7));
    emit(sw_word(7, 0, 12));
    emit(addi_word(1, 1, -1));
    emit(rtype_word(AND, 2, 1, 2));
    emit(branch_word(1'b0, 0, 0, 0));
    run_program("forwarding");
  endtask

  task automatic load_use_program();
    clear_program();
    emit(addi_word(1, 0, 64));
    emit(addi_word(2, 0, 123));
    emit(sw_word(2, 1, 4));
    emit(lw_word(3, 1, 4));
    emit(rtype_word(ADD, 4, 3, 2));
    emit(lw_word(5, 1, 4));
    emit(sw_word(5, 1, 8));  // load into store data
    emit(lw_word(6, 1, 8));
    emit(addi_word(7, 6, 1));
    emit(lw_word(1, 1, 4));
    emit(rtype_word(ADD, 2, 1, 1));
    emit(branch_word(1'b0, 0, 0, 0));
    run_program("load-use");
  endtask

  task automatic branch_program();
    clear_program();
    emit(addi_word(1, 0, 1));
    emit(addi_word(2, 0, 1));
    emit(addi_word(3, 0, 2));
    emit(branch_word(1'b0, 1, 2, 16));  // taken
    emit(addi_word(10, 0, 10));
    emit(addi_word(11, 0, 11));
    emit(sw_word(3, 0, 0));
    emit(branch_word(1'b1, 1, 2, 8));  // not taken
    emit(addi_word(12, 0, 12));
    emit(branch_word(1'b1, 1, 3, 16));
    emit(addi_word(13, 0, 13));
    emit(addi_word(14, 0, 14));
    emit(sw_word(1, 0, 4));
    emit(branch_word(1'b0, 1, 3, 8));
    emit(addi_word(15, 0, 15));
    emit(addi_word(4, 0, 2));
    emit(branch_word(1'b0, 4, 3, 16));  // operand forwarded
    emit(addi_word(16, 0, 16));
    emit(addi_word(17, 0, 17));
    emit(addi_word(18, 0, 18));
    emit(lw_word(5, 0, 0));
    emit(branch_word(1'b1, 5, 0, 8));  // stalls behind the load
    emit(addi_word(19, 0, 19));
    emit(sw_word(12, 0, 8));
    emit(branch_word(1'b0, 0, 0, 12));
    emit(branch_word(1'b0, 0, 0, 12));  // in the shadow, must not act
    emit(addi_word(20, 0, 20));
    emit(addi_word(21, 0, 21));
    emit(branch_word(1'b0, 0, 0, 0));
    run_program("branch");
  endtask

  task automatic random_program();
    int kind;
    int k;
    int rd;
    int rs1;
    int rs2;
    clear_program();
    for (int i = 0; i < RAND_LEN; i++) begin
      kind = $unsigned($random(seed)) % 10;
      rd   = pick_reg();
      rs1  = pick_reg();
      rs2  = pick_reg();
      case (kind)
        0, 1, 2: emit(addi_word(rd, rs1, $random(seed) % 64));
        3, 4, 5: emit(rtype_word(alu_op_t'($unsigned($random(seed)) % 6), rd, rs1, rs2));
        6:       emit(lw_word(rd, 0, 4 * ($unsigned($random(seed)) % 4)));
        7:       emit(sw_word(rs2, 0, 4 * ($unsigned($random(seed)) % 4)));
        default: begin
          k = 1 + $unsigned($random(seed)) % 4;  // forward only
          if (i + k > RAND_LEN) begin
            k = RAND_LEN - i;
          end
          emit(branch_word(kind == 9, rs1, rs2, 4 * k));
        end
      endcase
    end
    emit(branch_word(1'b0, 0, 0, 0));
    run_program("random");
  endtask

  initial begin
    reset      = 1'b1;
    start      = 1'b0;
    load_valid = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    repeat (4) @(negedge sys_clk);
    reset = 1'b0;
    alu_program();
    forwarding_program();
    load_use_program();
    branch_program();
    for (int p = 0; p < 3; p++) begin
      random_program();
    end
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+common
+incdir+bench
common/core_pkg.sv
design/instr_fetch.sv
design/instr_decode.sv
design/hazard_forward_unit.sv
design/execute_stage.sv
design/data_memory.sv
design/cpu_top.sv
bench/cpu_tb.sv

//--- Makefile
SIM      = verilator
TOP      = cpu_tb
FILELIST = flist.f
BUILD    = obj_dir
FLAGS    = --binary --timing -j 0 --top-module $(TOP) --Mdir $(BUILD)

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
